//--- hw/wbmem_array.sv
`timescale 1ns/1ps

module wbmem_array
    import wbmem_pkg::*;
(
    input  logic    clk_i,
    input  logic    arst_n_i,

    input  wb_req_t issue_i,
    input  logic    issue_valid_i,

    output word_t   rdata_o,
    output logic    ack_o
);

    word_t mem [2**ADDR_W];

    logic  wr_en;
    logic  rd_en;
    word_t rdata_q;
    logic  ack_q;

    assign wr_en = issue_valid_i && issue_i.we;
    assign rd_en = issue_valid_i && !issue_i.we;

    // byte merge of new data into an old word under sel
    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input sel_t sel);
        word_t res;
        res = old_w;
        for (int b = 0; b < SEL_W; b++) begin
            if (sel[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // storage, cleared on reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 2**ADDR_W; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[issue_i.addr] <= merge_bytes(mem[issue_i.addr], issue_i.wdata, issue_i.sel);
        end
    end

    // response, one cycle after the issue
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q   <= 1'b0;
            rdata_q <= '0;
        end else begin
            ack_q <= issue_valid_i;
            if (rd_en) begin
                rdata_q <= mem[issue_i.addr];
            end else begin
                rdata_q <= '0;          // zero on write acks and idle cycles
            end
        end
    end

    assign ack_o   = ack_q;
    assign rdata_o = rdata_q;

endmodule : wbmem_array

//--- hw/wbmem_delay_stage.sv
`timescale 1ns/1ps

module wbmem_delay_stage
    import wbmem_pkg::*;
(
    input  logic    clk_i,
    input  logic    arst_n_i,

    input  wb_req_t head_i,
    input  logic    head_valid_i,
    output logic    pop_o,

    output wb_req_t issue_o,
    output logic    issue_valid_o
);

    // sized for the longer of the two waits
    typedef logic [$clog2(SWITCH_DELAY+1)-1:0] wait_cnt_t;

    wait_cnt_t wait_cnt;        // cycles waited with a head present
    wait_cnt_t wait_len;
    logic      last_we;         // kind of the last issued request
    wb_req_t   issue_q;
    logic      issue_valid_q;

    // turnaround costs more than a repeat of the same kind
    assign wait_len = (head_i.we == last_we) ? wait_cnt_t'(SAME_DELAY)
                                             : wait_cnt_t'(SWITCH_DELAY);

    assign pop_o = head_valid_i && (wait_cnt == wait_len);

    // wait counter and last kind
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wait_cnt <= '0;
            last_we  <= 1'b0;           // behaves as if a read went last
        end else if (pop_o) begin
            wait_cnt <= '0;
            last_we  <= head_i.we;
        end else if (head_valid_i) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= pop_o;     // single-cycle issue strobe
        end
    end

    // payload, only meaningful with the strobe
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            issue_q <= head_i;
        end
    end

    assign issue_o       = issue_q;
    assign issue_valid_o = issue_valid_q;

endmodule : wbmem_delay_stage

//--- hw/wbmem_pkg.sv
package wbmem_pkg;

    // bus widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 8;              // word address, 256 words
    localparam int SEL_W  = DATA_W / 8;

    // queue sizing
    localparam int QUEUE_DEPTH = 4;

    // timing, all in clock cycles
    localparam int INIT_STALL   = 8;        // forced stall after reset release
    localparam int SAME_DELAY   = 2;        // same kind as the previous issue
    localparam int SWITCH_DELAY = 5;        // read after write or write after read

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [SEL_W-1:0]  sel_t;

    // one queued bus request, 45 bits
    typedef struct packed {
        logic  we;
        addr_t addr;
        sel_t  sel;
        word_t wdata;
    } wb_req_t;

    // start-up stall state of the request queue
    typedef enum logic {
        ST_STARTUP,
        ST_RUN
    } startup_state_t;

endpackage : wbmem_pkg

//--- hw/wbmem_req_queue.sv
`timescale 1ns/1ps

module wbmem_req_queue
    import wbmem_pkg::*;
(
    input  logic    clk_i,
    input  logic    arst_n_i,

    input  logic    req_valid_i,
    input  wb_req_t req_i,

    input  logic    pop_i,
    output wb_req_t head_o,
    output logic    head_valid_o,

    output logic    stall_o
);

    typedef logic [$clog2(QUEUE_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] count_t;
    typedef logic [$clog2(INIT_STALL)-1:0]    stall_cnt_t;

    startup_state_t state;
    stall_cnt_t     stall_cnt;

    wb_req_t        fifo_mem [QUEUE_DEPTH];
    ptr_t           rd_ptr;
    ptr_t           wr_ptr;
    count_t         count;

    logic           full;
    logic           push;
    logic           pop;

    // circular increment, depth need not be a power of two
    function automatic ptr_t ptr_inc(input ptr_t ptr);
        if (ptr == ptr_t'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // start-up stall timer
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state     <= ST_STARTUP;
            stall_cnt <= '0;
        end else if (state == ST_STARTUP) begin
            if (stall_cnt == stall_cnt_t'(INIT_STALL - 1)) begin
                state <= ST_RUN;        // last forced stall cycle
            end else begin
                stall_cnt <= stall_cnt + 1'b1;
            end
        end
    end

    assign full    = (count == count_t'(QUEUE_DEPTH));
    assign stall_o = (state == ST_STARTUP) || full;

    assign push = req_valid_i && !stall_o;  // bus handshake
    assign pop  = pop_i && head_valid_o;

    // pointers and fill level
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop)  rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle or push+pop
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_mem[wr_ptr] <= req_i;
        end
    end

    assign head_o       = fifo_mem[rd_ptr];
    assign head_valid_o = (count != '0);

endmodule : wbmem_req_queue

//--- hw/wbmem_top.sv
`timescale 1ns/1ps

module wbmem_top
    import wbmem_pkg::*;
(
    input  logic  clk_i,
    input  logic  arst_n_i,

    // pipelined wishbone slave
    input  logic  cyc_i,
    input  logic  stb_i,
    input  logic  we_i,
    input  addr_t addr_i,
    input  sel_t  sel_i,
    input  word_t wdata_i,

    output word_t rdata_o,
    output logic  ack_o,
    output logic  stall_o
);

    wb_req_t req;
    logic    req_valid;

    wb_req_t head;
    logic    head_valid;
    logic    pop;

    wb_req_t issue;
    logic    issue_valid;

    assign req = '{we: we_i, addr: addr_i, sel: sel_i, wdata: wdata_i};
    assign req_valid = cyc_i && stb_i;  // stall qualified inside the queue

    wbmem_req_queue i_req_queue (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid),
        .req_i        (req),
        .pop_i        (pop),
        .head_o       (head),
        .head_valid_o (head_valid),
        .stall_o      (stall_o)
    );

    wbmem_delay_stage i_delay_stage (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .head_i        (head),
        .head_valid_i  (head_valid),
        .pop_o         (pop),
        .issue_o       (issue),
        .issue_valid_o (issue_valid)
    );

    wbmem_array i_array (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .issue_i       (issue),
        .issue_valid_i (issue_valid),
        .rdata_o       (rdata_o),
        .ack_o         (ack_o)
    );

endmodule : wbmem_top

//--- list.f
hw/wbmem_pkg.sv
hw/wbmem_req_queue.sv
hw/wbmem_delay_stage.sv
hw/wbmem_array.sv
hw/wbmem_top.sv
tests/wbmem_properties.sv
tests/wbmem_tb.sv

//--- tests/wbmem_properties.sv
`timescale 1ns/1ps

module wbmem_properties
    import wbmem_pkg::*;
(
    input logic  clk_i,
    input logic  arst_n_i,
    input logic  cyc_i,
    input logic  stb_i,
    input logic  stall_i,
    input logic  pop_i,
    input logic  ack_i,
    input word_t rdata_i
);

    int   outstanding;          // accepted but not yet acked
    int   queued;               // accepted but not yet taken by the delay stage
    int   violations = 0;
    logic accept;

    assign accept = cyc_i && stb_i && !stall_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            outstanding <= 0;
            queued      <= 0;
        end else begin
            outstanding <= outstanding + int'(accept) - int'(ack_i);
            queued      <= queued + int'(accept) - int'(pop_i);
        end
    end

    ack_needs_request: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ack_i |-> (outstanding != 0))
        else begin
            $error("ack with no request outstanding");
            violations++;
        end

    rdata_zero_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !ack_i |-> (rdata_i == '0))
        else begin
            $error("rdata not zero outside an ack");
            violations++;
        end

    // queue full must back-pressure the bus
    stall_when_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (queued == QUEUE_DEPTH) |-> stall_i)
        else begin
            $error("queue full without stall");
            violations++;
        end

    startup_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(arst_n_i) |-> stall_i [*INIT_STALL] ##1 !stall_i)
        else begin
            $error("start-up stall has the wrong length");
            violations++;
        end

endmodule : wbmem_properties

bind wbmem_top wbmem_properties i_props (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .cyc_i    (cyc_i),
    .stb_i    (stb_i),
    .stall_i  (stall_o),
    .pop_i    (pop),
    .ack_i    (ack_o),
    .rdata_i  (rdata_o)
);

//--- tests/wbmem_tb.sv
`timescale 1ns/1ps

module wbmem_tb
    import wbmem_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;   // 66 requests at worst spacing plus gaps, start-up

    // one expected response, pushed at acceptance
    typedef struct packed {
        logic  we;
        logic  chained;     // head already waiting when the previous one issued
        word_t rdata;
        int    ack_cycle;
    } exp_t;

    logic   clk = 1'b0;
    logic   arst_n;
    logic   cyc;
    logic   stb;
    logic   we;
    addr_t  addr;
    sel_t   sel;
    word_t  wdata;
    word_t  rdata;
    logic   ack;
    logic   stall;

    word_t  ref_mem [2**ADDR_W];
    exp_t   exp_q [$];
    integer seed = 14476;
    int     cycle_cnt;                      // edges since reset release
    int     model_last_pop = -100;
    logic   model_last_we = 1'b0;           // reset kind is read
    int     prev_ack_cycle = 0;
    logic   prev_ack_we = 1'b0;
    logic   saw_backpressure = 1'b0;

    always #5 clk = ~clk;

    wbmem_top i_dut (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .cyc_i    (cyc),
        .stb_i    (stb),
        .we_i     (we),
        .addr_i   (addr),
        .sel_i    (sel),
        .wdata_i  (wdata),
        .rdata_o  (rdata),
        .ack_o    (ack),
        .stall_o  (stall)
    );

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) cycle_cnt <= 0;
        else         cycle_cnt <= cycle_cnt + 1;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    startup_closed: assert property (@(posedge clk) disable iff (!arst_n)
        (cycle_cnt < INIT_STALL) |-> (stall && !ack))
        else stop_with_error($sformatf("Fail at %0t ns: bus open during start-up", $time));

    startup_done: assert property (@(posedge clk) disable iff (!arst_n)
        (cycle_cnt == INIT_STALL) |-> !stall)
        else stop_with_error($sformatf("Fail at %0t ns: stall held past start-up", $time));

    // expected result and ack edge of an accepted request
    task automatic record_request();
        exp_t  entry;
        word_t mask;
        int    wait_len;
        int    pop_cycle;
        int    b;
        wait_len = (we == model_last_we) ? SAME_DELAY : SWITCH_DELAY;
        entry.chained = (cycle_cnt <= model_last_pop);
        pop_cycle = (entry.chained ? model_last_pop : cycle_cnt) + wait_len + 1;
        entry.ack_cycle = pop_cycle + 2;    // issue register, then ack register
        entry.we = we;
        mask = '0;
        for (b = 0; b < SEL_W; b++) begin
            mask[b*8 +: 8] = {8{sel[b]}};
        end
        if (we) begin
            ref_mem[addr] = (ref_mem[addr] & ~mask) | (wdata & mask);
            entry.rdata = '0;
        end else begin
            entry.rdata = ref_mem[addr];
        end
        exp_q.push_back(entry);
        model_last_pop = pop_cycle;
        model_last_we = we;
    endtask

    task automatic check_response();
        exp_t entry;
        int   gap;
        if (exp_q.size() == 0) begin
            stop_with_error($sformatf("Fail at %0t ns: ack with nothing expected", $time));
        end else begin
            entry = exp_q.pop_front();
            rdata_match: assert (rdata == entry.rdata)
                else stop_with_error($sformatf("Fail at %0t ns: rdata %h, expected %h",
                                               $time, rdata, entry.rdata));
            if (entry.chained) begin
                gap = (entry.we == prev_ack_we) ? SAME_DELAY + 1 : SWITCH_DELAY + 1;
                ack_spacing: assert (cycle_cnt - prev_ack_cycle == gap)
                    else stop_with_error($sformatf("Fail at %0t ns: ack spacing %0d, expected %0d",
                                                   $time, cycle_cnt - prev_ack_cycle, gap));
            end
            ack_timing: assert (cycle_cnt == entry.ack_cycle)
                else stop_with_error($sformatf("Fail at %0t ns: ack at cycle %0d, expected %0d",
                                               $time, cycle_cnt, entry.ack_cycle));
            prev_ack_cycle = cycle_cnt;
            prev_ack_we = entry.we;
        end
    endtask

    // acks first, they belong to earlier requests
    always @(posedge clk) begin
        if (arst_n) begin
            if (ack) check_response();
            if (cyc && stb && !stall) record_request();
            if (cyc && stb && stall && cycle_cnt > INIT_STALL) saw_backpressure = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("Timeout: acks still missing after %0d cycles", cycle_cnt));
        end else if (i_dut.i_props.violations != 0) begin
            stop_with_error("A bound protocol assertion on the DUT failed");
        end
    end

    task automatic wait_accept();
        do @(posedge clk); while (stall);
    endtask

    task automatic send_request(input logic w, input addr_t a, input sel_t s, input word_t d);
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we = w;
        addr = a;
        sel = s;
        wdata = d;
        wait_accept();
    endtask

    task automatic bus_idle();
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    initial begin
        int    i;
        int    gap;
        logic  rnd_we;
        addr_t rnd_addr;
        sel_t  rnd_sel;
        word_t rnd_data;
        for (i = 0; i < 2**ADDR_W; i++) ref_mem[i] = '0;
        // first write is held on the bus through reset and start-up
        arst_n = 1'b0;
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b1;
        addr = '0;
        sel = '1;
        wdata = word_t'($random(seed));
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        wait_accept();
        for (i = 1; i < 8; i++) begin
            rnd_data = $random(seed);
            send_request(1'b1, addr_t'(i), '1, rnd_data);
        end
        for (i = 0; i < 8; i++) begin      // partial masks over the full words
            rnd_sel = sel_t'($random(seed));
            rnd_data = $random(seed);
            send_request(1'b1, addr_t'(i), rnd_sel, rnd_data);
        end
        for (i = 0; i < 10; i++) send_request(1'b0, addr_t'(i), '0, '0);
        for (i = 0; i < 40; i++) begin
            rnd_we = 1'($random(seed));
            rnd_addr = addr_t'($random(seed) & 15);
            rnd_sel = sel_t'($random(seed));
            rnd_data = $random(seed);
            send_request(rnd_we, rnd_addr, rnd_sel, rnd_data);
            gap = {$random(seed)} % 3;
            if (gap != 0) begin
                bus_idle();
                repeat (gap - 1) @(negedge clk);
            end
        end
        bus_idle();
        while (exp_q.size() != 0) @(posedge clk);
        @(negedge clk);
        if (exp_q.size() == 0 && saw_backpressure && i_dut.i_props.violations == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_with_error("Run ended without back-pressure or with a failed protocol check");
        end
    end

endmodule : wbmem_tb
